// ==== common/eth_pkg.sv ====
package eth_pkg;

    // MII and frame data widths
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ethertype_t;

    // Station addresses
    localparam mac_addr_t LOCAL_MAC = 48'h00_1c_c0_a2_22_dd;
    localparam mac_addr_t BCAST_MAC = 48'hff_ff_ff_ff_ff_ff;

    // Frame format
    localparam ethertype_t CMD_ETHERTYPE = 16'h88b5;
    localparam byte_t      PREAMBLE_BYTE = 8'h55;
    localparam byte_t      SFD_BYTE      = 8'hd5;

    // Dst + src + EtherType, command byte follows
    localparam int HDR_BYTES = 14;

    // Commands carried in the first payload byte
    localparam byte_t CMD_DISCOVER = 8'h02;
    localparam byte_t CMD_START    = 8'h04;
    localparam byte_t CMD_STOP     = 8'h05;

    // Discovery reply payload
    localparam byte_t REPLY_CODE = 8'h12;
    localparam byte_t SERIAL_NO  = 8'd31;

    // Preamble, SFD, header and 3 payload bytes, two nibbles each
    localparam int REPLY_NIBBLES = 50;

    // Default LED on-time in clock cycles
    localparam int LED_HOLD_CYCLES = 10_000_000;

endpackage

// ==== ethernet/mii_rx.sv ====
`timescale 1ns/1ps

module mii_rx
    import eth_pkg::*;
(
    input  logic    phy_clk125,
    input  logic    reset_i,
    input  nibble_t phy_rx_i,
    input  logic    phy_rx_dv_i,
    output byte_t   rx_byte_o,
    output logic    rx_byte_stb_o,
    output logic    rx_frame_end_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA
    } rx_state_t;

    rx_state_t state_q;
    nibble_t   low_nib_q;
    logic      high_half_q;

    always_ff @(posedge phy_clk125) begin
        if (reset_i) begin
            state_q        <= RX_IDLE;
            high_half_q    <= 1'b0;
            rx_byte_stb_o  <= 1'b0;
            rx_frame_end_o <= 1'b0;
        end else begin
            rx_byte_stb_o  <= 1'b0;
            rx_frame_end_o <= 1'b0;

            if (!phy_rx_dv_i) begin
                // Only a frame that got past the SFD reports its end
                if (state_q == RX_DATA) begin
                    rx_frame_end_o <= 1'b1;
                end
                state_q     <= RX_IDLE;
                high_half_q <= 1'b0;
            end else begin
                case (state_q)
                    RX_IDLE: begin
                        if (phy_rx_i == PREAMBLE_BYTE[3:0]) begin
                            state_q <= RX_PREAMBLE;
                        end
                    end

                    RX_PREAMBLE: begin
                        // SFD arrives as 5 then D, low nibble first
                        if (phy_rx_i == SFD_BYTE[7:4]) begin
                            state_q     <= RX_DATA;
                            high_half_q <= 1'b0;
                        end else if (phy_rx_i != PREAMBLE_BYTE[3:0]) begin
                            state_q <= RX_IDLE;
                        end
                    end

                    RX_DATA: begin
                        if (!high_half_q) begin
                            low_nib_q   <= phy_rx_i;
                            high_half_q <= 1'b1;
                        end else begin
                            rx_byte_o     <= {phy_rx_i, low_nib_q};
                            rx_byte_stb_o <= 1'b1;
                            high_half_q   <= 1'b0;
                        end
                    end

                    default: begin
                        state_q <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // Byte strobes need dv high, frame end needs dv low
    a_stb_end_exclusive: assert property (
        @(posedge phy_clk125) disable iff (reset_i)
        !(rx_byte_stb_o && rx_frame_end_o)
    );

endmodule

// ==== ethernet/cmd_filter.sv ====
`timescale 1ns/1ps

module cmd_filter
    import eth_pkg::*;
(
    input  logic      phy_clk125,
    input  logic      reset_i,
    input  byte_t     rx_byte_i,
    input  logic      rx_byte_stb_i,
    input  logic      rx_frame_end_i,
    output logic      run_o,
    output logic      mac_hit_o,
    output logic      reply_stb_o,
    output mac_addr_t reply_mac_o
);

    logic [4:0] byte_cnt_q;
    mac_addr_t  dst_mac_q;
    mac_addr_t  src_mac_q;
    ethertype_t ethertype_q;
    byte_t      cmd_q;

    logic dst_local;
    logic dst_ok;
    logic frame_ok;

    // Field capture as bytes stream in, first byte most significant
    always_ff @(posedge phy_clk125) begin
        if (rx_byte_stb_i) begin
            if (byte_cnt_q < 5'd6) begin
                dst_mac_q <= {dst_mac_q[39:0], rx_byte_i};
            end else if (byte_cnt_q < 5'd12) begin
                src_mac_q <= {src_mac_q[39:0], rx_byte_i};
            end else if (byte_cnt_q < 5'(HDR_BYTES)) begin
                ethertype_q <= {ethertype_q[7:0], rx_byte_i};
            end else if (byte_cnt_q == 5'(HDR_BYTES)) begin
                cmd_q <= rx_byte_i;
            end
        end
    end

    always_ff @(posedge phy_clk125) begin
        if (reset_i) begin
            byte_cnt_q <= '0;
        end else if (rx_frame_end_i) begin
            byte_cnt_q <= '0;
        end else if (rx_byte_stb_i && byte_cnt_q != '1) begin
            // Saturates so long frames still pass the length check
            byte_cnt_q <= byte_cnt_q + 5'd1;
        end
    end

    assign dst_local = (dst_mac_q == LOCAL_MAC);
    assign dst_ok    = dst_local || (dst_mac_q == BCAST_MAC);
    assign frame_ok  = (byte_cnt_q > 5'(HDR_BYTES)) && dst_ok &&
                       (ethertype_q == CMD_ETHERTYPE);

    always_ff @(posedge phy_clk125) begin
        if (reset_i) begin
            run_o       <= 1'b0;
            mac_hit_o   <= 1'b0;
            reply_stb_o <= 1'b0;
        end else begin
            mac_hit_o   <= 1'b0;
            reply_stb_o <= 1'b0;
            if (rx_frame_end_i && frame_ok) begin
                mac_hit_o <= dst_local;
                case (cmd_q)
                    CMD_START:    run_o       <= 1'b1;
                    CMD_STOP:     run_o       <= 1'b0;
                    CMD_DISCOVER: reply_stb_o <= 1'b1;
                    default:      ;
                endcase
            end
        end
    end

    // Requester address, held until the next accepted frame
    always_ff @(posedge phy_clk125) begin
        if (rx_frame_end_i && frame_ok) begin
            reply_mac_o <= src_mac_q;
        end
    end

    a_run_at_frame_end: assert property (
        @(posedge phy_clk125) disable iff (reset_i)
        !$stable(run_o) |-> $past(rx_frame_end_i)
    );

    a_reply_single: assert property (
        @(posedge phy_clk125) disable iff (reset_i)
        reply_stb_o |=> !reply_stb_o
    );

endmodule

// ==== ethernet/mii_tx.sv ====
`timescale 1ns/1ps

module mii_tx
    import eth_pkg::*;
(
    input  logic      phy_clk125,
    input  logic      reset_i,
    input  logic      reply_stb_i,
    input  mac_addr_t reply_mac_i,
    input  logic      run_i,
    output nibble_t   phy_tx_o,
    output logic      phy_tx_en_o
);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t  state_q;
    logic [5:0] nib_cnt_q;
    mac_addr_t  mac_q;
    logic       run_q;

    logic [4:0] byte_idx;
    byte_t      tx_byte;
    nibble_t    tx_nib;

    assign byte_idx = nib_cnt_q[5:1];

    // Reply layout, one byte per index
    always_comb begin
        case (byte_idx)
            5'd0, 5'd1, 5'd2, 5'd3,
            5'd4, 5'd5, 5'd6:  tx_byte = PREAMBLE_BYTE;
            5'd7:              tx_byte = SFD_BYTE;
            5'd8:              tx_byte = mac_q[47:40];
            5'd9:              tx_byte = mac_q[39:32];
            5'd10:             tx_byte = mac_q[31:24];
            5'd11:             tx_byte = mac_q[23:16];
            5'd12:             tx_byte = mac_q[15:8];
            5'd13:             tx_byte = mac_q[7:0];
            5'd14:             tx_byte = LOCAL_MAC[47:40];
            5'd15:             tx_byte = LOCAL_MAC[39:32];
            5'd16:             tx_byte = LOCAL_MAC[31:24];
            5'd17:             tx_byte = LOCAL_MAC[23:16];
            5'd18:             tx_byte = LOCAL_MAC[15:8];
            5'd19:             tx_byte = LOCAL_MAC[7:0];
            5'd20:             tx_byte = CMD_ETHERTYPE[15:8];
            5'd21:             tx_byte = CMD_ETHERTYPE[7:0];
            5'd22:             tx_byte = REPLY_CODE;
            5'd23:             tx_byte = {7'd0, run_q};
            default:           tx_byte = SERIAL_NO;
        endcase
    end

    // Low nibble goes out first
    assign tx_nib = nib_cnt_q[0] ? tx_byte[7:4] : tx_byte[3:0];

    always_ff @(posedge phy_clk125) begin
        if (reset_i) begin
            state_q     <= TX_IDLE;
            nib_cnt_q   <= '0;
            phy_tx_o    <= '0;
            phy_tx_en_o <= 1'b0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (reply_stb_i) begin
                        // Nibble 0 is preamble, so it goes out without the latched fields
                        state_q     <= TX_SEND;
                        nib_cnt_q   <= 6'd1;
                        phy_tx_o    <= PREAMBLE_BYTE[3:0];
                        phy_tx_en_o <= 1'b1;
                    end
                end

                TX_SEND: begin
                    if (nib_cnt_q == 6'(REPLY_NIBBLES)) begin
                        state_q     <= TX_IDLE;
                        nib_cnt_q   <= '0;
                        phy_tx_o    <= '0;
                        phy_tx_en_o <= 1'b0;
                    end else begin
                        phy_tx_o  <= tx_nib;
                        nib_cnt_q <= nib_cnt_q + 6'd1;
                    end
                end

                default: begin
                    state_q <= TX_IDLE;
                end
            endcase
        end
    end

    // Requester and run state frozen for the whole reply
    always_ff @(posedge phy_clk125) begin
        if (state_q == TX_IDLE && reply_stb_i) begin
            mac_q <= reply_mac_i;
            run_q <= run_i;
        end
    end

    a_quiet_when_idle: assert property (
        @(posedge phy_clk125) disable iff (reset_i)
        !phy_tx_en_o |-> (phy_tx_o == '0)
    );

endmodule

// ==== hdl/led_flash.sv ====
`timescale 1ns/1ps

module led_flash
    import eth_pkg::*;
#(
    parameter int HOLD = LED_HOLD_CYCLES
) (
    input  logic phy_clk125,
    input  logic reset_i,
    input  logic signal_i,
    output logic led_o
);

    localparam int CNT_W = $clog2(HOLD + 1);

    logic [CNT_W-1:0] hold_cnt_q;

    always_ff @(posedge phy_clk125) begin
        if (reset_i) begin
            hold_cnt_q <= '0;
        end else if (signal_i) begin
            hold_cnt_q <= CNT_W'(HOLD);
        end else if (hold_cnt_q != '0) begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
        end
    end

    // Lit for HOLD cycles past the last high input
    assign led_o = (hold_cnt_q != '0);

endmodule

// ==== hdl/radio_ctrl_top.sv ====
`timescale 1ns/1ps

module radio_ctrl_top
    import eth_pkg::*;
#(
    parameter int LED_HOLD = LED_HOLD_CYCLES
) (
    input  logic    phy_clk125,
    input  logic    reset_i,
    input  nibble_t phy_rx_i,
    input  logic    phy_rx_dv_i,
    output nibble_t phy_tx_o,
    output logic    phy_tx_en_o,
    output logic    run_o,
    output logic    led_mac_o,
    output logic    led_run_o
);

    byte_t     rx_byte;
    logic      rx_byte_stb;
    logic      rx_frame_end;
    logic      mac_hit;
    logic      reply_stb;
    mac_addr_t reply_mac;

    mii_rx i_mii_rx (
        .phy_clk125     (phy_clk125),
        .reset_i        (reset_i),
        .phy_rx_i       (phy_rx_i),
        .phy_rx_dv_i    (phy_rx_dv_i),
        .rx_byte_o      (rx_byte),
        .rx_byte_stb_o  (rx_byte_stb),
        .rx_frame_end_o (rx_frame_end)
    );

    cmd_filter i_cmd_filter (
        .phy_clk125     (phy_clk125),
        .reset_i        (reset_i),
        .rx_byte_i      (rx_byte),
        .rx_byte_stb_i  (rx_byte_stb),
        .rx_frame_end_i (rx_frame_end),
        .run_o          (run_o),
        .mac_hit_o      (mac_hit),
        .reply_stb_o    (reply_stb),
        .reply_mac_o    (reply_mac)
    );

    mii_tx i_mii_tx (
        .phy_clk125  (phy_clk125),
        .reset_i     (reset_i),
        .reply_stb_i (reply_stb),
        .reply_mac_i (reply_mac),
        .run_i       (run_o),
        .phy_tx_o    (phy_tx_o),
        .phy_tx_en_o (phy_tx_en_o)
    );

    // Address hit flasher
    led_flash #(.HOLD(LED_HOLD)) i_led_mac (
        .phy_clk125 (phy_clk125),
        .reset_i    (reset_i),
        .signal_i   (mac_hit),
        .led_o      (led_mac_o)
    );

    // Run state flasher
    led_flash #(.HOLD(LED_HOLD)) i_led_run (
        .phy_clk125 (phy_clk125),
        .reset_i    (reset_i),
        .signal_i   (run_o),
        .led_o      (led_run_o)
    );

endmodule

// ==== bench/radio_ctrl_tb.sv ====
`timescale 1ns/1ps

module radio_ctrl_tb
    import eth_pkg::*;
();

    localparam int LED_HOLD        = 64;
    localparam int NUM_FRAMES      = 11;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 120 + 2000;
    localparam int REPLY_BYTES     = 25;

    // Source address for frames whose nibbles must never look like an SFD
    localparam mac_addr_t QUIET_SRC = 48'h02_00_00_00_00_01;

    logic    phy_clk125;
    logic    reset_i;
    nibble_t phy_rx_i;
    logic    phy_rx_dv_i;
    nibble_t phy_tx_o;
    logic    phy_tx_en_o;
    logic    run_o;
    logic    led_mac_o;
    logic    led_run_o;

    mac_addr_t exp_mac;
    logic      exp_run;
    nibble_t   cur_nibs[$];
    nibble_t   done_nibs[$];
    int        replies_done = 0;
    int        replies_checked = 0;
    int        tx_starts = 0;
    int        mac_rises = 0;
    logic      tx_en_prev = 1'b0;
    logic      led_mac_prev = 1'b0;
    logic      run_prev = 1'b0;
    int        test_errors = 0;
    int        cmp_errors = 0;
    int        mon_errors = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        test_base = 0;

    radio_ctrl_top #(.LED_HOLD(LED_HOLD)) i_radio_ctrl_top (
        .phy_clk125  (phy_clk125),
        .reset_i     (reset_i),
        .phy_rx_i    (phy_rx_i),
        .phy_rx_dv_i (phy_rx_dv_i),
        .phy_tx_o    (phy_tx_o),
        .phy_tx_en_o (phy_tx_en_o),
        .run_o       (run_o),
        .led_mac_o   (led_mac_o),
        .led_run_o   (led_run_o)
    );

    initial begin
        phy_clk125 = 1'b0;
        forever #20 phy_clk125 = ~phy_clk125;
    end

    // Reply as sent: preamble, SFD, requester, own address, EtherType, payload
    function automatic logic [8*REPLY_BYTES-1:0] expected_reply(input mac_addr_t requester,
                                                                 input logic running);
        logic [8*REPLY_BYTES-1:0] frame;
        frame = {{7{PREAMBLE_BYTE}}, SFD_BYTE, requester, LOCAL_MAC, CMD_ETHERTYPE,
                 REPLY_CODE, {7'd0, running}, SERIAL_NO};
        return frame;
    endfunction

    function automatic int total_errors();
        return test_errors + cmp_errors + mon_errors;
    endfunction

    function automatic byte_t pick_junk_cmd();
        byte_t c;
        do begin
            c = 8'($urandom());
        end while (c == CMD_DISCOVER || c == CMD_START || c == CMD_STOP);
        return c;
    endfunction

    always @(negedge phy_clk125) begin : collect_tx
        if (phy_tx_en_o) begin
            cur_nibs.push_back(phy_tx_o);
        end
        if (phy_tx_en_o && !tx_en_prev) begin
            tx_starts++;
        end
        if (!phy_tx_en_o && tx_en_prev) begin
            done_nibs = cur_nibs;
            cur_nibs.delete();
            replies_done++;
        end
        tx_en_prev = phy_tx_en_o;
    end

    always @(posedge phy_clk125) begin : compare_reply
        logic [8*REPLY_BYTES-1:0] exp_frame;
        byte_t                    exp_byte;
        nibble_t                  exp_nib;
        int                       k;
        if (replies_checked < replies_done) begin
            exp_frame = expected_reply(exp_mac, exp_run);
            if (done_nibs.size() != 2 * REPLY_BYTES) begin
                $display("reply held %0d nibbles instead of %0d", done_nibs.size(),
                         2 * REPLY_BYTES);
                cmp_errors++;
            end
            for (k = 0; k < done_nibs.size() && k < 2 * REPLY_BYTES; k++) begin
                exp_byte = exp_frame[8*(REPLY_BYTES-1-k/2) +: 8];
                exp_nib  = (k % 2 == 0) ? exp_byte[3:0] : exp_byte[7:4];
                if (done_nibs[k] !== exp_nib) begin
                    $display("error: phy_tx_o nibble %0d got %h expected %h", k, done_nibs[k],
                             exp_nib);
                    cmp_errors++;
                end
            end
            replies_checked++;
        end
    end

    // Run LED must follow a steady run level
    always @(negedge phy_clk125) begin : watch_leds
        if (led_mac_o && !led_mac_prev) begin
            mac_rises++;
        end
        if (!reset_i && run_prev && run_o && !led_run_o) begin
            $display("error: led_run_o got %h expected 1 while run_o is high", led_run_o);
            mon_errors++;
        end
        led_mac_prev = led_mac_o;
        run_prev     = run_o;
    end

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == test_base) begin
            $display("test %-20s ok", name);
        end else begin
            $display("test %-20s failed", name);
            tests_failed++;
        end
        test_base = total_errors();
    endtask

    task automatic send_byte(input byte_t b);
        @(posedge phy_clk125);
        #2;
        phy_rx_dv_i = 1'b1;
        phy_rx_i    = b[3:0];
        @(posedge phy_clk125);
        #2;
        phy_rx_i    = b[7:4];
    endtask

    task automatic send_frame(input mac_addr_t dst, input mac_addr_t src,
                              input ethertype_t etype, input byte_t cmd,
                              input int body_bytes, input logic with_sfd, input int gap);
        logic [119:0] body;
        int           i;
        body = {dst, src, etype, cmd};
        repeat (gap) @(posedge phy_clk125);
        for (i = 0; i < 7; i++) begin
            send_byte(PREAMBLE_BYTE);
        end
        send_byte(with_sfd ? SFD_BYTE : PREAMBLE_BYTE);
        for (i = 0; i < body_bytes; i++) begin
            send_byte(body[119-8*i -: 8]);
        end
        @(posedge phy_clk125);
        #2;
        phy_rx_dv_i = 1'b0;
        phy_rx_i    = '0;
    endtask

    // Run level must settle within three cycles of dv falling
    task automatic check_run(input logic expected);
        int cycles;
        cycles = 0;
        while (run_o !== expected && cycles < 3) begin
            @(negedge phy_clk125);
            cycles++;
        end
        expect_bit("run_o", run_o, expected);
    endtask

    task automatic led_on_time(input logic run_led, output int cycles);
        int waited;
        cycles = 0;
        waited = 0;
        while (!(run_led ? led_run_o : led_mac_o) && waited < 8) begin
            @(negedge phy_clk125);
            waited++;
        end
        while ((run_led ? led_run_o : led_mac_o) && cycles < 4 * LED_HOLD) begin
            cycles++;
            @(negedge phy_clk125);
        end
    endtask

    task automatic wait_led_mac_off();
        int n;
        n = 0;
        while (led_mac_o && n < 4 * LED_HOLD) begin
            @(negedge phy_clk125);
            n++;
        end
    endtask

    // Rejected frames are sent while the radio is stopped
    task automatic reject_case(input string name, input mac_addr_t dst, input ethertype_t etype,
                               input byte_t cmd, input int body_bytes, input logic with_sfd);
        int starts0;
        int macs0;
        starts0 = tx_starts;
        macs0   = mac_rises;
        send_frame(dst, QUIET_SRC, etype, cmd, body_bytes, with_sfd, $urandom_range(4, 11));
        repeat (10) @(negedge phy_clk125);
        expect_bit("run_o", run_o, 1'b0);
        expect_bit("led_mac_o", led_mac_o, 1'b0);
        expect_bit("led_run_o", led_run_o, 1'b0);
        if (mac_rises != macs0) begin
            $display("led_mac_o flashed for a rejected frame");
            test_errors++;
        end
        if (tx_starts != starts0) begin
            $display("a reply went out for a rejected frame");
            test_errors++;
        end
        end_test(name);
    endtask

    // Later requests follow with a one-cycle gap while the first reply runs
    task automatic discover_case(input string name, input logic running, input int requests);
        int done0;
        int n;
        int i;
        exp_mac = 48'({$urandom(), $urandom()});
        exp_run = running;
        done0   = replies_done;
        send_frame(LOCAL_MAC, exp_mac, CMD_ETHERTYPE, CMD_DISCOVER, 15, 1'b1,
                   $urandom_range(4, 11));
        for (i = 1; i < requests; i++) begin
            send_frame(LOCAL_MAC, 48'({$urandom(), $urandom()}), CMD_ETHERTYPE, CMD_DISCOVER,
                       15, 1'b1, 0);
        end
        n = 0;
        while (replies_checked < done0 + 1 && n < 120) begin
            @(negedge phy_clk125);
            n++;
        end
        repeat (60) @(negedge phy_clk125);
        if (replies_done != done0 + 1) begin
            $display("%0d replies came back instead of one", replies_done - done0);
            test_errors++;
        end
        end_test(name);
    endtask

    initial begin : main
        int macs0;
        int on_cycles;
        void'($urandom(32'h18c6cf61));
        reset_i     = 1'b1;
        phy_rx_i    = '0;
        phy_rx_dv_i = 1'b0;
        exp_mac     = '0;
        exp_run     = 1'b0;
        repeat (8) @(posedge phy_clk125);
        #2;
        reset_i = 1'b0;
        @(negedge phy_clk125);
        expect_bit("phy_tx_en_o", phy_tx_en_o, 1'b0);
        expect_bit("run_o", run_o, 1'b0);
        expect_bit("led_mac_o", led_mac_o, 1'b0);
        expect_bit("led_run_o", led_run_o, 1'b0);
        end_test("reset state");

        reject_case("wrong destination", LOCAL_MAC ^ 48'h1, CMD_ETHERTYPE, CMD_START, 15, 1'b1);
        reject_case("wrong ethertype", LOCAL_MAC, 16'h0800, CMD_START, 15, 1'b1);
        reject_case("missing sfd", LOCAL_MAC, CMD_ETHERTYPE, CMD_START, 15, 1'b0);
        reject_case("cut after header", LOCAL_MAC, CMD_ETHERTYPE, CMD_START, 14, 1'b1);
        reject_case("unknown command", BCAST_MAC, CMD_ETHERTYPE, pick_junk_cmd(), 15, 1'b1);

        discover_case("discovery stopped", 1'b0, 1);

        wait_led_mac_off();
        send_frame(LOCAL_MAC, QUIET_SRC, CMD_ETHERTYPE, CMD_START, 15, 1'b1,
                   $urandom_range(4, 11));
        check_run(1'b1);
        led_on_time(1'b0, on_cycles);
        if (on_cycles != LED_HOLD) begin
            $display("error: led_mac_o on-time got %h expected %h", on_cycles, LED_HOLD);
            test_errors++;
        end
        end_test("start and mac led");

        discover_case("discovery running", 1'b1, 1);
        discover_case("busy drop", 1'b1, 2);

        wait_led_mac_off();
        macs0 = mac_rises;
        send_frame(BCAST_MAC, QUIET_SRC, CMD_ETHERTYPE, CMD_STOP, 15, 1'b1,
                   $urandom_range(4, 11));
        check_run(1'b0);
        led_on_time(1'b1, on_cycles);
        if (on_cycles != LED_HOLD) begin
            $display("error: led_run_o on-time got %h expected %h", on_cycles, LED_HOLD);
            test_errors++;
        end
        if (mac_rises != macs0) begin
            $display("led_mac_o flashed for a broadcast frame");
            test_errors++;
        end
        end_test("stop and run led");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge phy_clk125);
        $display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== list.f ====
common/eth_pkg.sv
ethernet/mii_rx.sv
ethernet/cmd_filter.sv
ethernet/mii_tx.sv
hdl/led_flash.sv
hdl/radio_ctrl_top.sv
bench/radio_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module radio_ctrl_tb \
    -f list.f -Mdir obj_dir -o radio_ctrl_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/radio_ctrl_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
